// File: bench/pe_checker.sv
`timescale 1ns/1ps

module pe_checker (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic                   i_rd_en,
  input pe_mem_pkg::buf_addr_t  i_rd_addr,
  input logic                   i_fwd_rd_en,
  input pe_mem_pkg::buf_addr_t  i_fwd_rd_addr,
  input pe_data_pkg::wgt_word_t i_fwd_weight
);

  // Forwarded enable trails the input by one cycle
  a_fwd_en: assert property (
    @(posedge i_clk) $past(i_rst_n) |-> i_fwd_rd_en == $past(i_rd_en)
  ) else $error("forwarded read enable does not follow the input enable");

  a_fwd_addr: assert property (
    @(posedge i_clk) $past(i_rst_n) && i_fwd_rd_en |-> i_fwd_rd_addr == $past(i_rd_addr)
  ) else $error("forwarded read address does not match the issued address");

  // Outputs cleared one cycle into reset
  a_reset: assert property (
    @(posedge i_clk) !i_rst_n |=> !i_fwd_rd_en && i_fwd_weight == '0
  ) else $error("forwarded enable or weight not cleared by reset");

endmodule

bind processing_element pe_checker u_pe_checker (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_rd_en       (i_act_rd_en),
  .i_rd_addr     (i_buf_rd_addr),
  .i_fwd_rd_en   (o_act_rd_en),
  .i_fwd_rd_addr (o_buf_rd_addr),
  .i_fwd_weight  (o_load_weight)
);

// File: bench/pe_input.txt
# test kind go a b c (hex a b c) | W shift a=word | S set | B write a=addr b=data
# R read a=addr b=acc base c=1 random | E expect a=0 load weight, 1 o_acc b=row*4+lane, 2 rd_en
# go=0 issues the record in the same cycle as the next one
# reset values
1 E 1 0 0 0
1 E 1 1 5 0
1 E 1 2 0 0
# write then read, write and read together, back-to-back reads
2 B 1 05 0A1B2C3 0
2 B 0 06 1234567 0
2 R 1 05 0 0
2 R 1 06 0 0
2 E 1 1 6 6
# weight chain
3 W 1 01020304 0 0
3 W 1 11121314 0 0
3 W 1 21222324 0 0
3 W 1 31323334 0 0
3 E 1 0 0 01020304
3 W 1 41424344 0 0
3 W 1 F1E2D3C4 0 0
3 E 1 0 0 21222324
# set isolation
4 S 1 0 0 0
4 R 1 05 00100 0
4 W 1 7F7F7F7F 0 0
4 R 1 05 00100 0
4 E 1 1 0 FF14C
4 E 1 1 5 1B74
4 S 1 0 0 0
4 R 1 05 00100 0
4 E 1 1 0 223D
4 E 1 1 5 FEF44
# back-to-back MAC with random sums and wraparound
5 R 1 05 0 1
5 R 1 06 0 1
5 R 1 05 7FF80 0
5 E 1 1 0 820BD
5 R 1 05 80010 0
5 E 1 1 5 7EE54

// File: bench/tb_processing_element.sv
`timescale 1ns/1ps

module tb_processing_element;
  import pe_data_pkg::*;
  import pe_mem_pkg::*;

  localparam int N_ROWS = 4;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  logic      buf_wr_en = 1'b0;
  buf_addr_t buf_wr_addr = '0;
  act_word_t buf_data = '0;
  logic      act_rd_en = 1'b0;
  buf_addr_t buf_rd_addr = '0;
  logic      prepare_weight = 1'b0;
  logic      set_weight = 1'b0;
  wgt_word_t load_weight = '0;
  acc_t      acc_in  [N_ROWS][N_LANES];
  logic      fwd_rd_en;
  buf_addr_t fwd_rd_addr;
  wgt_word_t weight_out;
  acc_t      acc_out [N_ROWS][N_LANES];

  // Reference model
  act_word_t   img     [BUF_DEPTH];
  wgt_word_t   chain   [N_ROWS];
  wgt_word_t   active  [N_ROWS];
  acc_t        exp_acc [N_ROWS][N_LANES];
  logic        exp_rd_en = 1'b0;
  buf_addr_t   exp_rd_addr = '0;
  logic        s1_valid = 1'b0;
  act_word_t   s1_act = '0;
  logic [31:0] rd_base = '0;
  logic        rd_random = 1'b0;

  // Records from the data file
  int          rec_test [$];
  logic [7:0]  rec_kind [$];
  int          rec_go   [$];
  logic [31:0] rec_a    [$];
  logic [31:0] rec_b    [$];
  logic [31:0] rec_c    [$];

  integer seed = 87;
  int     cycles = 0;
  int     limit = 0;
  int     test_errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  logic   bad_file = 1'b0;

  processing_element #(
    .N_ROWS (N_ROWS)
  ) i_dut (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_buf_wr_en      (buf_wr_en),
    .i_buf_wr_addr    (buf_wr_addr),
    .i_buf_data       (buf_data),
    .i_act_rd_en      (act_rd_en),
    .i_buf_rd_addr    (buf_rd_addr),
    .o_act_rd_en      (fwd_rd_en),
    .o_buf_rd_addr    (fwd_rd_addr),
    .i_prepare_weight (prepare_weight),
    .i_set_weight     (set_weight),
    .i_load_weight    (load_weight),
    .o_load_weight    (weight_out),
    .i_acc            (acc_in),
    .o_acc            (acc_out)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the tests did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic log_error(input string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic check_acc(input acc_t got, input acc_t exp, input string what);
    if (got !== exp) begin
      log_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_weight(input wgt_word_t got, input wgt_word_t exp, input string what);
    if (got !== exp) begin
      log_error($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_addr(input buf_addr_t got, input buf_addr_t exp, input string what);
    if (got !== exp) begin
      log_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      log_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // Zero-extended mantissa times signed weight, wrapped to the accumulator
  function automatic acc_t mac_ref(input acc_t acc, input act_t act, input wgt_t wgt);
    int total;
    total = int'(acc) + int'(act) * int'(wgt);
    return acc_t'(total);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One clock cycle of model update and output checks
  //////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
    // MAC for the read of the previous edge uses weights set before this edge
    for (int r = 0; r < N_ROWS; r++) begin
      for (int l = 0; l < N_LANES; l++) begin
        if (s1_valid) begin
          exp_acc[r][l] = mac_ref(acc_in[r][l], s1_act[l], active[r][l]);
        end
        check_acc(acc_out[r][l], exp_acc[r][l], $sformatf("o_acc[%0d][%0d]", r, l));
      end
    end
    // Set sees the chain before a shift on the same edge
    if (set_weight) begin
      active = chain;
    end
    if (prepare_weight) begin
      for (int s = N_ROWS - 1; s > 0; s--) begin
        chain[s] = chain[s-1];
      end
      chain[0] = load_weight;
    end
    s1_valid  = act_rd_en;
    exp_rd_en = act_rd_en;
    if (act_rd_en) begin
      s1_act      = img[buf_rd_addr];
      exp_rd_addr = buf_rd_addr;
    end
    if (buf_wr_en) begin
      img[buf_wr_addr] = buf_data;
    end
    check_bit(fwd_rd_en, exp_rd_en, "o_act_rd_en");
    if (exp_rd_en) begin
      check_addr(fwd_rd_addr, exp_rd_addr, "o_buf_rd_addr");
    end
    check_weight(weight_out, chain[N_ROWS-1], "o_load_weight");
    // Accumulator inputs for the read just issued
    if (s1_valid) begin
      for (int r = 0; r < N_ROWS; r++) begin
        for (int l = 0; l < N_LANES; l++) begin
          if (rd_random) begin
            acc_in[r][l] = acc_t'($random(seed));
          end else begin
            acc_in[r][l] = acc_t'(rd_base + 32'(r * N_LANES + l));
          end
        end
      end
    end
    buf_wr_en      = 1'b0;
    act_rd_en      = 1'b0;
    prepare_weight = 1'b0;
    set_weight     = 1'b0;
  endtask

  task automatic check_expected(input int idx);
    int r;
    int l;
    acc_t file_acc;
    r = int'(rec_b[idx]) / N_LANES;
    l = int'(rec_b[idx]) % N_LANES;
    file_acc = acc_t'(rec_c[idx]);
    case (rec_a[idx])
      0: begin
        if (wgt_word_t'(rec_c[idx]) !== chain[N_ROWS-1]) begin
          log_error($sformatf("file weight %h differs from model", rec_c[idx]));
        end
        check_weight(weight_out, wgt_word_t'(rec_c[idx]), "o_load_weight");
      end
      1: begin
        // Sums settle once no read is in flight
        while (fwd_rd_en !== 1'b0) begin
          step();
        end
        if (file_acc !== exp_acc[r][l]) begin
          log_error($sformatf("file sum %0d differs from model %0d", file_acc, exp_acc[r][l]));
        end
        check_acc(acc_out[r][l], file_acc, $sformatf("o_acc[%0d][%0d]", r, l));
      end
      default: begin
        if (rec_c[idx][0] !== exp_rd_en) begin
          log_error($sformatf("file read enable %b differs from model", rec_c[idx][0]));
        end
        check_bit(fwd_rd_en, rec_c[idx][0], "o_act_rd_en");
      end
    endcase
  endtask

  task automatic apply_record(input int idx);
    case (rec_kind[idx])
      "W": begin
        prepare_weight = 1'b1;
        load_weight    = wgt_word_t'(rec_a[idx]);
      end
      "S": set_weight = 1'b1;
      "B": begin
        buf_wr_en   = 1'b1;
        buf_wr_addr = buf_addr_t'(rec_a[idx]);
        buf_data    = act_word_t'(rec_b[idx]);
      end
      "R": begin
        act_rd_en   = 1'b1;
        buf_rd_addr = buf_addr_t'(rec_a[idx]);
        rd_base     = rec_b[idx];
        rd_random   = rec_c[idx][0];
      end
      "E": check_expected(idx);
      default: begin
        $display("record %0d has an unknown kind and was not applied", idx);
        test_errors++;
      end
    endcase
    if (rec_kind[idx] != "E" && rec_go[idx] != 0) begin
      step();
    end
  endtask

  task automatic load_records();
    int          fd;
    int          n;
    int          test;
    int          go;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    string       line;
    fd = $fopen("bench/pe_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/pe_input.txt");
      bad_file = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%d %c %d %h %h %h", test, kind, go, a, b, c);
        if (n == 6) begin
          rec_test.push_back(test);
          rec_kind.push_back(kind);
          rec_go.push_back(go);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
        end else begin
          $display("stimulus line could not be parsed: %s", line);
          bad_file = 1'b1;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic finish_test(input int num);
    while (fwd_rd_en !== 1'b0) begin
      step();
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d: ok", num);
    end else begin
      tests_failed++;
      $display("test %0d: %0d errors", num, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int cur_test;
    for (int r = 0; r < N_ROWS; r++) begin
      chain[r]  = '0;
      active[r] = '0;
      for (int l = 0; l < N_LANES; l++) begin
        acc_in[r][l]  = '0;
        exp_acc[r][l] = '0;
      end
    end
    load_records();
    limit = rec_test.size() * 4 + 50;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    cur_test = -1;
    for (int i = 0; i < rec_test.size(); i++) begin
      if (rec_test[i] != cur_test) begin
        if (cur_test >= 0) begin
          finish_test(cur_test);
        end
        cur_test = rec_test[i];
      end
      apply_record(i);
    end
    if (cur_test >= 0) begin
      finish_test(cur_test);
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && !bad_file && rec_test.size() > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the processing element testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_processing_element -o sim_pe -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_pe 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: src/activation_buffer.sv
`timescale 1ns/1ps

module activation_buffer (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_buf_wr_en,
  input  pe_mem_pkg::buf_addr_t  i_buf_wr_addr,
  input  pe_data_pkg::act_word_t i_buf_data,
  input  logic                   i_act_rd_en,
  input  pe_mem_pkg::buf_addr_t  i_buf_rd_addr,
  output logic                   o_act_rd_en,
  output pe_mem_pkg::buf_addr_t  o_buf_rd_addr,
  output pe_data_pkg::act_word_t o_act_data,
  output logic                   o_act_valid
);
  import pe_data_pkg::*;
  import pe_mem_pkg::*;

  act_word_t mem [BUF_DEPTH];

  logic      rd_en_q;
  buf_addr_t rd_addr_q;
  act_word_t rd_data_q;

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_buf_wr_en) begin
      mem[i_buf_wr_addr] <= i_buf_data;
    end
  end

  // Registered read, word held between reads
  always_ff @(posedge i_clk) begin
    if (i_act_rd_en) begin
      rd_data_q <= mem[i_buf_rd_addr];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Forwarding to the next element
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= i_act_rd_en;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_addr_q <= i_buf_rd_addr;
  end

  assign o_act_rd_en   = rd_en_q;
  assign o_buf_rd_addr = rd_addr_q;

  // Same cycle as the data, qualifies the MAC update
  assign o_act_valid = rd_en_q;
  assign o_act_data  = rd_data_q;

endmodule

// File: src/mac_rows.sv
`timescale 1ns/1ps

module mac_rows #(
  parameter int N_ROWS = 4
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_act_valid,
  input  pe_data_pkg::act_word_t i_act_data,
  input  pe_data_pkg::wgt_word_t i_weight [N_ROWS],
  input  pe_data_pkg::acc_t      i_acc    [N_ROWS][pe_data_pkg::N_LANES],
  output pe_data_pkg::acc_t      o_acc    [N_ROWS][pe_data_pkg::N_LANES]
);
  import pe_data_pkg::*;

  acc_t sum   [N_ROWS][N_LANES];
  acc_t acc_q [N_ROWS][N_LANES];

  // Unsigned mantissa times signed weight, wrapped to ACC_W
  function automatic acc_t mul_lane(input act_t act, input wgt_t wgt);
    acc_t act_ext;
    acc_t wgt_ext;
    act_ext = acc_t'(act);
    wgt_ext = acc_t'(wgt);
    return act_ext * wgt_ext;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Multiply and add
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int r = 0; r < N_ROWS; r++) begin
      for (int l = 0; l < N_LANES; l++) begin
        sum[r][l] = i_acc[r][l] + mul_lane(i_act_data[l], i_weight[r][l]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////

  // Holds the last sums while no activation arrives
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < N_ROWS; r++) begin
        for (int l = 0; l < N_LANES; l++) begin
          acc_q[r][l] <= '0;
        end
      end
    end else if (i_act_valid) begin
      for (int r = 0; r < N_ROWS; r++) begin
        for (int l = 0; l < N_LANES; l++) begin
          acc_q[r][l] <= sum[r][l];
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < N_ROWS; r++) begin
      for (int l = 0; l < N_LANES; l++) begin
        o_acc[r][l] = acc_q[r][l];
      end
    end
  end

endmodule

// File: src/pe_data_pkg.sv
package pe_data_pkg;

  ////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////

  // Lanes a to d, lane a in the low bits
  localparam int N_LANES = 4;

  // Quantized activation mantissa
  localparam int ACT_W = 7;

  localparam int WGT_W = 8;

  // Partial sum carried between neighbouring elements
  localparam int ACC_W = 20;

  ////////////////////////////////////////////////////////////////////
  // Datapath types
  ////////////////////////////////////////////////////////////////////

  typedef logic        [ACT_W-1:0] act_t;
  typedef logic signed [WGT_W-1:0] wgt_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  typedef act_t [N_LANES-1:0] act_word_t;
  typedef wgt_t [N_LANES-1:0] wgt_word_t;

endpackage

// File: src/pe_mem_pkg.sv
package pe_mem_pkg;

  ////////////////////////////////////////////////////////////////////
  // Activation buffer geometry
  ////////////////////////////////////////////////////////////////////

  localparam int BUF_AW = 6;

  // Fully decoded address space
  localparam int BUF_DEPTH = 64;

  typedef logic [BUF_AW-1:0] buf_addr_t;

endpackage

// File: src/processing_element.sv
`timescale 1ns/1ps

module processing_element #(
  parameter int N_ROWS = 4
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // Buffer write side
  input  logic                   i_buf_wr_en,
  input  pe_mem_pkg::buf_addr_t  i_buf_wr_addr,
  input  pe_data_pkg::act_word_t i_buf_data,

  // Read control, forwarded to the next element
  input  logic                   i_act_rd_en,
  input  pe_mem_pkg::buf_addr_t  i_buf_rd_addr,
  output logic                   o_act_rd_en,
  output pe_mem_pkg::buf_addr_t  o_buf_rd_addr,

  // Weight load
  input  logic                   i_prepare_weight,
  input  logic                   i_set_weight,
  input  pe_data_pkg::wgt_word_t i_load_weight,
  output pe_data_pkg::wgt_word_t o_load_weight,

  // Partial sums in from and out to the neighbours
  input  pe_data_pkg::acc_t      i_acc [N_ROWS][pe_data_pkg::N_LANES],
  output pe_data_pkg::acc_t      o_acc [N_ROWS][pe_data_pkg::N_LANES]
);
  import pe_data_pkg::*;

  act_word_t act_data;
  logic      act_valid;
  wgt_word_t active_weight [N_ROWS];

  ////////////////////////////////////////////////////////////////////
  // Activation path
  ////////////////////////////////////////////////////////////////////

  activation_buffer u_activation_buffer (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_buf_wr_en   (i_buf_wr_en),
    .i_buf_wr_addr (i_buf_wr_addr),
    .i_buf_data    (i_buf_data),
    .i_act_rd_en   (i_act_rd_en),
    .i_buf_rd_addr (i_buf_rd_addr),
    .o_act_rd_en   (o_act_rd_en),
    .o_buf_rd_addr (o_buf_rd_addr),
    .o_act_data    (act_data),
    .o_act_valid   (act_valid)
  );

  ////////////////////////////////////////////////////////////////////
  // Weights and MAC array
  ////////////////////////////////////////////////////////////////////

  weight_bank #(
    .N_ROWS (N_ROWS)
  ) u_weight_bank (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_prepare_weight (i_prepare_weight),
    .i_set_weight     (i_set_weight),
    .i_load_weight    (i_load_weight),
    .o_load_weight    (o_load_weight),
    .o_active_weight  (active_weight)
  );

  mac_rows #(
    .N_ROWS (N_ROWS)
  ) u_mac_rows (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_act_valid (act_valid),
    .i_act_data  (act_data),
    .i_weight    (active_weight),
    .i_acc       (i_acc),
    .o_acc       (o_acc)
  );

endmodule

// File: src/weight_bank.sv
`timescale 1ns/1ps

module weight_bank #(
  parameter int N_ROWS = 4
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_prepare_weight,
  input  logic                   i_set_weight,
  input  pe_data_pkg::wgt_word_t i_load_weight,
  output pe_data_pkg::wgt_word_t o_load_weight,
  output pe_data_pkg::wgt_word_t o_active_weight [N_ROWS]
);
  import pe_data_pkg::*;

  wgt_word_t chain  [N_ROWS];
  wgt_word_t active [N_ROWS];

  ////////////////////////////////////////////////////////////////////
  // Weight chain
  ////////////////////////////////////////////////////////////////////

  // Stage 0 is fed from the previous element
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int s = 0; s < N_ROWS; s++) begin
        chain[s] <= '0;
      end
    end else if (i_prepare_weight) begin
      chain[0] <= i_load_weight;
      for (int s = 1; s < N_ROWS; s++) begin
        chain[s] <= chain[s-1];
      end
    end
  end

  // Last stage continues down the array
  assign o_load_weight = chain[N_ROWS-1];

  ////////////////////////////////////////////////////////////////////
  // Active weights
  ////////////////////////////////////////////////////////////////////

  // Copies the chain as it stood before any shift in the same cycle
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int r = 0; r < N_ROWS; r++) begin
        active[r] <= '0;
      end
    end else if (i_set_weight) begin
      for (int r = 0; r < N_ROWS; r++) begin
        active[r] <= chain[r];
      end
    end
  end

  // Stage r steers MAC row r
  always_comb begin
    for (int r = 0; r < N_ROWS; r++) begin
      o_active_weight[r] = active[r];
    end
  end

endmodule

// File: tb.f
src/pe_data_pkg.sv
src/pe_mem_pkg.sv
src/activation_buffer.sv
src/weight_bank.sv
src/mac_rows.sv
src/processing_element.sv
bench/pe_checker.sv
bench/tb_processing_element.sv
